// ==== eeprom_tests.txt ====
# name op addr_or_sel(hex) value(hex) err ; op C config, W write, R read
# B write then read back to back, err column is the read's expected error
wr_page0 W 005 a5 0
wr_page3 W 3c2 5a 0
wr_page7 W 7ff c3 0
rd_page0 R 005 a5 0
rd_page3 R 3c2 5a 0
rd_page7 R 7ff c3 0
rd_fill R 412 34 0
div_6 C 0 6 0
wr_div6 W 123 11 0
rd_div6 R 123 11 0
div_1 C 0 1 0
rd_div1 R 7ff c3 0
rec_20 C 1 14 0
busy_short B 234 77 1
rec_200 C 1 c8 0
busy_long B 456 88 0

// ==== eeprom_sys.f ====
+incdir+.
eeprom_pkg.sv
i2c_bit_if.sv
eeprom_cfg_regs.sv
i2c_bit_engine.sv
eeprom_master.sv
eeprom_sys.sv
eeprom_sys_assertions.sv
eeprom_sys_tb.sv

// ==== Bender.yml ====
package:
  name: eeprom_sys

sources:
  - include_dirs:
      - .
    files:
      - eeprom_pkg.sv
      - i2c_bit_if.sv
      - eeprom_cfg_regs.sv
      - i2c_bit_engine.sv
      - eeprom_master.sv
      - eeprom_sys.sv
  - target: test
    include_dirs:
      - .
    files:
      - eeprom_sys_assertions.sv
      - eeprom_sys_tb.sv

// ==== eeprom_sys_tb.sv ====
`timescale 1ns/1ps
`include "eeprom_cfg.svh"
module eeprom_sys_tb;
    localparam int MODEL_BUSY = 150;   // eeprom write cycle in clk cycles
    localparam int M_IDLE = 0, M_CTRL = 1, M_ADDR = 2, M_WDATA = 3, M_RDATA = 4, M_SKIP = 5;

    logic CLK, RESET;
    logic cmd_valid, cmd_write, cmd_credit, rsp_valid, rsp_err;
    logic [10:0] cmd_addr;
    logic [7:0] cmd_wdata, rsp_rdata;
    logic cfg_we, cfg_sel, scl, sda_oe;
    logic [15:0] cfg_wdata;
    logic m_pull;
    wire sda_bus = !(sda_oe || m_pull);   // open-drain wire with pull-up

    string t_name[$], t_op[$];
    int t_a[$], t_v[$], t_e[$];
    string cur_name = "reset_state";
    int test_err, n_pass, n_fail, credits, credit_seen, cycles, limit;
    int exp_div = `EEPROM_DIV_RESET;
    int exp_rec = `EEPROM_REC_RESET;
    logic rsp_err_q[$];
    logic [7:0] rsp_data_q[$];
    logic [7:0] shadow [2048];
    logic [7:0] mem [2048];

    // bus model state
    int m_state, m_bits, m_busy, ph_len;
    logic [7:0] m_shift, m_lo, m_tx;
    logic [2:0] m_page;
    logic m_ack, m_wrote, prev_scl, prev_sda, hi_track;

    eeprom_sys eeprom_sys_inst (.*, .sda_in(sda_bus));

    bind eeprom_sys eeprom_sys_assertions assertions_inst (
        .CLK(CLK), .RESET(RESET), .cmd_valid(cmd_valid), .cmd_credit(cmd_credit),
        .rsp_valid(rsp_valid), .scl(scl), .sda_oe(sda_oe), .req(bus_if.req),
        .done(bus_if.done), .state(master_inst.state)
    );

    always #20 CLK = !CLK;

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout after %0d cycles in %s, no response from DUT",
                     cycles, cur_name);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    always @(posedge CLK)
    begin
        if (!RESET && cmd_credit)
        begin
            credits = credits + 1;
            credit_seen++;
        end
        if (!RESET && rsp_valid)
        begin
            rsp_err_q.push_back(rsp_err);
            rsp_data_q.push_back(rsp_rdata);
        end
    end

    // eeprom model plus scl phase monitor
    always @(posedge CLK)
    begin
        if (m_busy > 0)
            m_busy = m_busy - 1;
        if (scl == prev_scl)
            ph_len++;
        else
        begin
            if (!scl && hi_track)
                assert (ph_len == exp_div)
                else
                begin
                    $display("ERR %s scl high expected %0d actual %0d",
                             cur_name, exp_div, ph_len);
                    test_err++;
                end
            if (scl && m_state >= M_CTRL && m_state <= M_RDATA && m_bits >= 1 && m_bits <= 8)
                assert (ph_len == exp_div)
                else
                begin
                    $display("ERR %s scl low expected %0d actual %0d",
                             cur_name, exp_div, ph_len);
                    test_err++;
                end
            hi_track = scl && (m_state != M_IDLE);
            ph_len = 1;
        end
        if (RESET)
        begin
            m_state = M_IDLE;
            m_wrote = 0;
            m_pull <= 1'b0;
        end
        else if (prev_scl && scl && prev_sda && !sda_bus)
        begin
            m_state = M_CTRL;   // start or repeated start
            m_bits = 0;
            hi_track = 0;
        end
        else if (prev_scl && scl && !prev_sda && sda_bus)
        begin
            if (m_wrote)
                m_busy = MODEL_BUSY;
            m_wrote = 0;
            m_state = M_IDLE;
            hi_track = 0;
        end
        else if (!prev_scl && scl)
        begin
            if (m_state >= M_CTRL && m_state <= M_WDATA && m_bits < 8)
                m_shift = {m_shift[6:0], sda_bus};
            if (m_state >= M_CTRL && m_state <= M_RDATA)
                m_bits++;
        end
        else if (prev_scl && !scl)
        begin
            if (m_state == M_RDATA)
                m_pull <= (m_bits < 8) ? !m_tx[7 - m_bits] : 1'b0;
            else if (m_state >= M_CTRL && m_state <= M_WDATA && m_bits == 8)
            begin
                m_ack = (m_state != M_CTRL) || (m_shift[7:4] == 4'b1010 && m_busy == 0);
                m_pull <= m_ack;
            end
            else if (m_state >= M_CTRL && m_state <= M_WDATA && m_bits == 9)
            begin
                m_pull <= 1'b0;
                m_bits = 0;
                if (m_state == M_CTRL && !m_ack)
                    m_state = M_IDLE;
                else if (m_state == M_CTRL)
                begin
                    m_page = m_shift[3:1];
                    m_state = m_shift[0] ? M_RDATA : M_ADDR;
                    m_tx = mem[{m_page, m_lo}];
                    if (m_shift[0])
                        m_pull <= !m_tx[7];
                end
                else if (m_state == M_ADDR)
                begin
                    m_lo = m_shift;
                    m_state = M_WDATA;
                end
                else
                begin
                    mem[{m_page, m_lo}] = m_shift;
                    m_wrote = 1;
                    m_state = M_SKIP;
                end
            end
        end
        prev_scl = scl;
        prev_sda = sda_bus;
    end

    task automatic check_val(input string what, input int exp, input int act);
        assert (exp == act)
        else
        begin
            $display("ERR %s %s expected %0h actual %0h", cur_name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic report_result();
        $display("%s %s", (test_err == 0) ? "PASS" : "FAIL", cur_name);
        if (test_err == 0)
            n_pass++;
        else
            n_fail++;
    endtask

    task automatic send_cmd(input logic wr, input int addr, input int data);
        while (credits == 0)
            @(posedge CLK);
        cmd_valid <= 1'b1;
        cmd_write <= wr;
        cmd_addr  <= addr[10:0];
        cmd_wdata <= data[7:0];
        credits = credits - 1;
        @(posedge CLK);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_rsp(input int n);
        while (rsp_err_q.size() < n)
            @(posedge CLK);
    endtask

    task automatic run_test(input int i);
        int a, v, e, first_credit, read_err;
        a = t_a[i];
        v = t_v[i];
        e = t_e[i];
        first_credit = credit_seen;
        if (t_op[i] == "C")
        begin
            cfg_we    <= 1'b1;
            cfg_sel   <= a[0];
            cfg_wdata <= v[15:0];
            @(posedge CLK);
            cfg_we <= 1'b0;
            if (a[0])
                exp_rec = v;
            else
                exp_div = (v < 2) ? 2 : (v > 255) ? 255 : v;
            repeat (160) @(posedge CLK);    // let the memory finish any write
        end
        else if (t_op[i] == "W")
        begin
            send_cmd(1'b1, a, v);
            wait_rsp(1);
            check_val("rsp_err", e, rsp_err_q.pop_front());
            void'(rsp_data_q.pop_front());
            if (e == 0)
                shadow[a] = v[7:0];
            check_val("credits", 1, credit_seen - first_credit);
        end
        else
        begin
            if (t_op[i] == "B")
            begin
                send_cmd(1'b1, a, v);
                shadow[a] = v[7:0];
            end
            else
                assert (v[7:0] == shadow[a])
                else
                begin
                    $display("%s: data file value %0h disagrees with tracked memory %0h",
                             cur_name, v, shadow[a]);
                    test_err++;
                end
            send_cmd(1'b0, a, 0);
            if (t_op[i] == "B")
            begin
                wait_rsp(2);
                check_val("write rsp_err", 0, rsp_err_q.pop_front());
                void'(rsp_data_q.pop_front());
                read_err = (exp_rec < MODEL_BUSY) ? 1 : 0;
                check_val("expected err column", read_err, e);
                check_val("credits", 2, credit_seen - first_credit);
            end
            else
            begin
                wait_rsp(1);
                read_err = e;
                check_val("credits", 1, credit_seen - first_credit);
            end
            check_val("rsp_err", read_err, rsp_err_q.pop_front());
            if (read_err == 0)
                check_val("rsp_rdata", shadow[a], rsp_data_q[0]);
            void'(rsp_data_q.pop_front());
        end
    endtask

    initial
    begin
        int fd, n;
        string line, nm, opc;
        int a, v, e, div_now, rec_now;
        CLK = 0;
        RESET = 1;
        cmd_valid = 0;
        cmd_write = 0;
        cmd_addr = '0;
        cmd_wdata = '0;
        cfg_we = 0;
        cfg_sel = 0;
        cfg_wdata = '0;
        m_pull = 0;
        prev_scl = 1;
        prev_sda = 1;
        credits = `EEPROM_CMD_DEPTH;
        limit = 2000;
        for (int i = 0; i < 2048; i++)
        begin
            mem[i] = i[7:0] ^ {2'b00, i[10:8], 3'b110};
            shadow[i] = mem[i];
        end
        div_now = exp_div;
        rec_now = exp_rec;
        fd = $fopen("eeprom_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open eeprom_tests.txt, no tests loaded");
            n_fail++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 3 || line[0] == "#")
                    continue;
                n = $sscanf(line, "%s %s %h %h %d", nm, opc, a, v, e);
                if (n != 5)
                    continue;
                t_name.push_back(nm);
                t_op.push_back(opc);
                t_a.push_back(a);
                t_v.push_back(v);
                t_e.push_back(e);
                if (opc == "C" && a == 0)
                    div_now = (v < 2) ? 2 : v;
                else if (opc == "C")
                    rec_now = v;
                // a read is about 80 scl phases, a write about 60 plus its recovery
                limit += (opc == "C") ? 200 : (opc == "B") ? 140 * div_now + rec_now + 200
                                                           : 70 * div_now + rec_now + 100;
            end
            $fclose(fd);
        end
        limit = 2 * limit;
        repeat (8) @(posedge CLK);
        RESET <= 1'b0;
        repeat (4) @(posedge CLK);
        test_err = 0;
        check_val("scl", 1, scl);
        check_val("sda_oe", 0, sda_oe);
        check_val("credit pulses", 0, credit_seen);
        check_val("responses", 0, rsp_err_q.size());
        report_result();
        for (int i = 0; i < t_name.size(); i++)
        begin
            cur_name = t_name[i];
            test_err = 0;
            @(posedge CLK);
            run_test(i);
            report_result();
        end
        $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end
endmodule

// ==== eeprom_sys_assertions.sv ====
`timescale 1ns/1ps
`include "eeprom_cfg.svh"
module eeprom_sys_assertions
    import eeprom_pkg::*;
(
    input logic          CLK,
    input logic          RESET,
    input logic          cmd_valid,
    input logic          cmd_credit,
    input logic          rsp_valid,
    input logic          scl,
    input logic          sda_oe,
    input logic          req,
    input logic          done,
    input master_state_e state
);
    int credits;    // host view of free queue slots

    always @(posedge CLK)
    begin
        if (RESET)
            credits <= `EEPROM_CMD_DEPTH;
        else
            credits <= credits - int'(cmd_valid) + int'(cmd_credit);
    end

    a_credit: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> credits > 0)
        else $error("cmd_valid while the host holds no credit");

    a_reset_idle: assert property (@(posedge CLK)
        $fell(RESET) |-> scl && !sda_oe && state == IDLE)
        else $error("bus or sequencer not idle after reset");

    a_rsp_pulse: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid longer than one cycle");

    a_req_hold: assert property (@(posedge CLK) disable iff (RESET)
        req && !done |=> req)
        else $error("req dropped before done");
endmodule

// ==== eeprom_sys.sv ====
`timescale 1ns/1ps
module eeprom_sys (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        cmd_valid,
    input  logic        cmd_write,
    input  logic [10:0] cmd_addr,
    input  logic [7:0]  cmd_wdata,
    output logic        cmd_credit,
    output logic        rsp_valid,
    output logic [7:0]  rsp_rdata,
    output logic        rsp_err,
    input  logic        cfg_we,
    input  logic        cfg_sel,
    input  logic [15:0] cfg_wdata,
    output logic        scl,
    output logic        sda_oe,     // high pulls sda low
    input  logic        sda_in
);
    logic [7:0]  div;
    logic [15:0] rec_time;

    i2c_bit_if bus_if ();

    eeprom_cfg_regs cfg_regs_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .cfg_we    (cfg_we),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .div       (div),
        .rec_time  (rec_time)
    );

    eeprom_master master_inst (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd_write  (cmd_write),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_err    (rsp_err),
        .rec_time   (rec_time),
        .bus        (bus_if.master)
    );

    i2c_bit_engine engine_inst (
        .CLK    (CLK),
        .RESET  (RESET),
        .div    (div),
        .bus    (bus_if.engine),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );
endmodule

// ==== eeprom_master.sv ====
`timescale 1ns/1ps
`include "eeprom_cfg.svh"
module eeprom_master
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        cmd_valid,
    input  logic        cmd_write,
    input  logic [10:0] cmd_addr,
    input  logic [7:0]  cmd_wdata,
    output logic        cmd_credit,
    output logic        rsp_valid,
    output logic [7:0]  rsp_rdata,
    output logic        rsp_err,
    input  logic [15:0] rec_time,
    i2c_bit_if.master   bus
);
    localparam int DEPTH = `EEPROM_CMD_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic          q_write [DEPTH];
    logic [10:0]   q_addr  [DEPTH];
    logic [7:0]    q_wdata [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [2:0]    count;
    logic          push;
    logic          pop;

    master_state_e state;
    logic          cur_write;
    logic [10:0]   cur_addr;
    logic [7:0]    cur_wdata;
    logic          err;
    logic [7:0]    rdata;
    logic [15:0]   rec_cnt;
    logic          req_q;
    logic          rsp_q;

    assign push = cmd_valid;    // host only sends while holding a credit
    assign pop  = (state == IDLE) && (count != 3'd0);

    always_ff @(posedge CLK)
    begin
        if (push)
        begin
            q_write[wr_ptr] <= cmd_write;
            q_addr[wr_ptr]  <= cmd_addr;
            q_wdata[wr_ptr] <= cmd_wdata;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 3'd0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 3'd1;
            else if (pop && !push)
                count <= count - 3'd1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= IDLE;
            req_q   <= 1'b0;
            rsp_q   <= 1'b0;
            err     <= 1'b0;
            rec_cnt <= 16'd0;
        end
        else
        begin
            rsp_q <= 1'b0;
            case (state)
                IDLE:
                    if (pop)
                    begin
                        state <= START;
                        err   <= 1'b0;
                    end
                RECOVER:
                    if (rec_cnt == 16'd0)
                    begin
                        rsp_q <= 1'b1;
                        state <= IDLE;
                    end
                    else
                        rec_cnt <= rec_cnt - 16'd1;
                default:
                    if (bus.done)
                    begin
                        req_q <= 1'b0;
                        if (bus.op == OP_WRITE_BYTE && !bus.ack_seen)
                            err <= 1'b1;
                        case (state)
                            START:   state <= CTRL_WR;
                            CTRL_WR: state <= bus.ack_seen ? ADDR : STOP;
                            ADDR:
                                if (!bus.ack_seen)
                                    state <= STOP;
                                else if (cur_write)
                                    state <= DATA_WR;
                                else
                                    state <= RESTART;
                            DATA_WR: state <= STOP;
                            RESTART: state <= CTRL_RD;
                            CTRL_RD: state <= bus.ack_seen ? DATA_RD : STOP;
                            DATA_RD: state <= STOP;
                            STOP:
                                if (cur_write && !err)
                                begin
                                    state   <= RECOVER;   // memory busy with its write cycle
                                    rec_cnt <= rec_time;
                                end
                                else
                                begin
                                    rsp_q <= 1'b1;
                                    state <= IDLE;
                                end
                            default: state <= IDLE;
                        endcase
                    end
                    else if (!req_q)
                        req_q <= 1'b1;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (pop)
        begin
            cur_write <= q_write[rd_ptr];
            cur_addr  <= q_addr[rd_ptr];
            cur_wdata <= q_wdata[rd_ptr];
        end
        if (bus.done && state == DATA_RD)
            rdata <= bus.rx_byte;
    end

    always_comb
    begin
        bus.op      = OP_WRITE_BYTE;
        bus.tx_byte = 8'h00;
        case (state)
            START, RESTART: bus.op = OP_START;
            STOP:           bus.op = OP_STOP;
            DATA_RD:        bus.op = OP_READ_BYTE;
            CTRL_WR:        bus.tx_byte = {4'b1010, cur_addr[10:8], 1'b0};
            ADDR:           bus.tx_byte = cur_addr[7:0];
            DATA_WR:        bus.tx_byte = cur_wdata;
            CTRL_RD:        bus.tx_byte = {4'b1010, cur_addr[10:8], 1'b1};
            default:        bus.op = OP_WRITE_BYTE;
        endcase
    end

    assign bus.req      = req_q;
    assign bus.send_ack = 1'b0;   // single-byte reads always end with nack
    assign cmd_credit   = pop;
    assign rsp_valid    = rsp_q;
    assign rsp_rdata    = rdata;
    assign rsp_err      = err;
endmodule

// ==== i2c_bit_engine.sv ====
`timescale 1ns/1ps
module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic [7:0] div,
    i2c_bit_if.engine  bus,
    output logic       scl,
    output logic       sda_oe,
    input  logic       sda_in
);
    bus_op_e    cur_op;
    logic       busy;
    logic       accept;
    logic [7:0] div_q;
    logic [7:0] phase_cnt;  // counts down each half-period
    logic [3:0] bit_cnt;    // 0..8, bit 8 is the ack slot
    logic       half;       // 0 low half, 1 high half
    logic [7:0] shreg;
    logic       ack_q;
    logic       done_q;
    logic       scl_q;
    logic       sda_oe_q;
    logic       mid;
    logic       phase_end;
    logic       last_half;

    assign accept    = !busy && bus.req && !done_q;
    assign mid       = busy && (phase_cnt == (div_q >> 1));
    assign phase_end = busy && (phase_cnt == 8'd0);
    assign last_half = half && ((cur_op == OP_START) || (cur_op == OP_STOP) ||
                                (bit_cnt == 4'd8));

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy      <= 1'b0;
            done_q    <= 1'b0;
            scl_q     <= 1'b1;    // bus released
            sda_oe_q  <= 1'b0;
            phase_cnt <= 8'd0;
            bit_cnt   <= 4'd0;
            half      <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (accept)
            begin
                busy      <= 1'b1;
                phase_cnt <= div - 8'd1;
                bit_cnt   <= 4'd0;
                half      <= 1'b0;
                if (bus.op == OP_START)
                    sda_oe_q <= 1'b0;     // release first, scl may still be low
                else if (bus.op == OP_STOP)
                    sda_oe_q <= 1'b1;
            end
            else if (busy)
            begin
                // sda only moves mid-phase, never next to an scl edge
                if (mid)
                begin
                    case (cur_op)
                        OP_START:      if (half) sda_oe_q <= 1'b1;
                        OP_STOP:       if (half) sda_oe_q <= 1'b0;
                        OP_WRITE_BYTE: if (!half) sda_oe_q <= (bit_cnt != 4'd8) && !shreg[7];
                        OP_READ_BYTE:  if (!half) sda_oe_q <= (bit_cnt == 4'd8) && bus.send_ack;
                        default:       sda_oe_q <= sda_oe_q;
                    endcase
                end
                if (phase_end)
                begin
                    phase_cnt <= div_q - 8'd1;
                    if (!half)
                    begin
                        half  <= 1'b1;
                        scl_q <= 1'b1;
                    end
                    else if (last_half)
                    begin
                        busy   <= 1'b0;
                        done_q <= 1'b1;
                        scl_q  <= (cur_op == OP_STOP);  // stop leaves scl high
                    end
                    else
                    begin
                        half    <= 1'b0;
                        scl_q   <= 1'b0;
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                else
                    phase_cnt <= phase_cnt - 8'd1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cur_op <= bus.op;
            div_q  <= div;
            shreg  <= bus.tx_byte;
        end
        else if (mid && !half && (cur_op == OP_WRITE_BYTE) && (bit_cnt != 4'd8))
            shreg <= {shreg[6:0], 1'b0};
        else if (phase_end && half && (cur_op == OP_READ_BYTE) && (bit_cnt != 4'd8))
            shreg <= {shreg[6:0], sda_in};   // msb first
        if (phase_end && half && (cur_op == OP_WRITE_BYTE) && (bit_cnt == 4'd8))
            ack_q <= !sda_in;
    end

    assign bus.done     = done_q;
    assign bus.rx_byte  = shreg;
    assign bus.ack_seen = ack_q;
    assign scl          = scl_q;
    assign sda_oe       = sda_oe_q;
endmodule

// ==== eeprom_cfg_regs.sv ====
`timescale 1ns/1ps
`include "eeprom_cfg.svh"
module eeprom_cfg_regs (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        cfg_we,
    input  logic        cfg_sel,    // 0 divider, 1 recovery time
    input  logic [15:0] cfg_wdata,
    output logic [7:0]  div,
    output logic [15:0] rec_time
);
    logic [7:0] div_clamped;

    // half-period of at least 2 keeps a mid-phase point for sda changes
    always_comb
    begin
        if (cfg_wdata > 16'd255)
            div_clamped = 8'd255;
        else if (cfg_wdata[7:0] < 8'd2)
            div_clamped = 8'd2;
        else
            div_clamped = cfg_wdata[7:0];
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            div      <= `EEPROM_DIV_RESET;
            rec_time <= `EEPROM_REC_RESET;
        end
        else if (cfg_we)
        begin
            if (!cfg_sel)
                div <= div_clamped;
            else
                rec_time <= cfg_wdata;
        end
    end
endmodule

// ==== i2c_bit_if.sv ====
`timescale 1ns/1ps
interface i2c_bit_if
    import eeprom_pkg::*;
();
    logic       req;
    bus_op_e    op;
    logic [7:0] tx_byte;
    logic       send_ack;   // low sends nack after a read byte

    logic       done;       // one-cycle pulse
    logic [7:0] rx_byte;
    logic       ack_seen;   // slave pulled sda low on the 9th clock

    modport master (
        output req, op, tx_byte, send_ack,
        input  done, rx_byte, ack_seen
    );

    modport engine (
        input  req, op, tx_byte, send_ack,
        output done, rx_byte, ack_seen
    );
endinterface

// ==== eeprom_pkg.sv ====
package eeprom_pkg;

    // operations the bus engine understands
    typedef enum logic [1:0] {
        OP_START      = 2'd0,  // start or repeated start
        OP_STOP       = 2'd1,
        OP_WRITE_BYTE = 2'd2,
        OP_READ_BYTE  = 2'd3
    } bus_op_e;

    // transaction sequencer
    typedef enum logic [3:0] {
        IDLE    = 4'd0,
        START   = 4'd1,
        CTRL_WR = 4'd2,
        ADDR    = 4'd3,
        DATA_WR = 4'd4,
        RESTART = 4'd5,
        CTRL_RD = 4'd6,
        DATA_RD = 4'd7,
        STOP    = 4'd8,
        RECOVER = 4'd9
    } master_state_e;

endpackage

// ==== eeprom_cfg.svh ====
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// command queue entries, also the host's starting credits (1 to 4)
`define EEPROM_CMD_DEPTH 2

// scl half-period in clk cycles
`define EEPROM_DIV_RESET 8'd4

// idle clk cycles after a write
`define EEPROM_REC_RESET 16'd200

`endif
